/* rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Lane 2 carries the oldest instruction of a group, lane 0 the youngest
`define RN_LANES 3

`define RN_NUM_AR 32
`define RN_NUM_PR 64
`define RN_AR_W 5
`define RN_PR_W 6

`define RN_FL_DEPTH (`RN_NUM_PR - `RN_NUM_AR)

`endif

/* rename_pkg.sv */
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

	typedef logic [`RN_AR_W-1:0] ar_idx_t;
	typedef logic [`RN_PR_W-1:0] pr_idx_t;

	// One instruction entering rename
	typedef struct packed {
		logic valid;
		ar_idx_t arch_dest;
		ar_idx_t arch_src1;
		ar_idx_t arch_src2;
	} rename_req_t;

	typedef struct packed {
		pr_idx_t phys_src1;
		pr_idx_t phys_src2;
		pr_idx_t phys_dest;
		pr_idx_t old_phys_dest;
	} rename_rsp_t;

	// phys_dest is the register that becomes architectural
	typedef struct packed {
		logic valid;
		ar_idx_t arch_dest;
		pr_idx_t phys_dest;
	} retire_t;

endpackage

`default_nettype wire

/* free_list.sv */
`default_nettype none

`include "rename_defines.svh"

module free_list (
	input logic clock,
	input logic reset,
	input logic flush,
	input logic [`RN_LANES-1:0] pop,
	input logic [`RN_LANES-1:0] push,
	input rename_pkg::pr_idx_t [`RN_LANES-1:0] push_reg,
	output rename_pkg::pr_idx_t [`RN_LANES-1:0] alloc_reg,
	output logic [`RN_LANES-1:0] ready
);

	localparam int PTR_W = $clog2(`RN_FL_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	rename_pkg::pr_idx_t [`RN_FL_DEPTH-1:0] entries;

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic full;

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic [CNT_W-1:0] pop_count;
	logic [CNT_W-1:0] push_count;
	logic [PTR_W-1:0] head_next;
	logic [PTR_W-1:0] tail_next;
	logic [`RN_LANES-1:0][PTR_W-1:0] pop_ptr;
	logic [`RN_LANES-1:0][PTR_W-1:0] push_ptr;

	// Head equals tail both when empty and when full, the flag tells them apart
	assign count = full ? CNT_W'(`RN_FL_DEPTH) : {1'b0, tail - head};

	// Lane l needs RN_LANES - l free entries, which gives 100, 110, 111
	always_comb begin
		for (int l = 0; l < `RN_LANES; l++) begin
			ready[l] = (count >= CNT_W'(`RN_LANES - l));
		end
	end

	// Walk from the oldest lane down so the oldest request takes the head
	always_comb begin
		pop_count = '0;
		push_count = '0;
		for (int l = `RN_LANES - 1; l >= 0; l--) begin
			pop_ptr[l] = head + PTR_W'(pop_count);
			push_ptr[l] = tail + PTR_W'(push_count);
			pop_count = pop_count + CNT_W'(pop[l]);
			push_count = push_count + CNT_W'(push[l]);
		end
	end

	always_comb begin
		for (int l = 0; l < `RN_LANES; l++) begin
			alloc_reg[l] = entries[pop_ptr[l]];
		end
	end

	assign head_next = head + PTR_W'(pop_count);
	assign tail_next = tail + PTR_W'(push_count);
	assign count_next = count + push_count - pop_count;

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			full <= 1'b1;
		end else if (flush) begin
			// Every register that is not architectural becomes free again
			head <= tail_next;
			tail <= tail_next;
			full <= 1'b1;
		end else begin
			head <= head_next;
			tail <= tail_next;
			full <= (count_next == CNT_W'(`RN_FL_DEPTH));
		end
	end

	// Pushes still land during a flush
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RN_FL_DEPTH; i++) begin
				entries[i] <= rename_pkg::pr_idx_t'(i + `RN_NUM_AR);
			end
		end else begin
			for (int l = `RN_LANES - 1; l >= 0; l--) begin
				if (push[l]) begin
					entries[push_ptr[l]] <= push_reg[l];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* map_table.sv */
`default_nettype none

`include "rename_defines.svh"

module map_table (
	input logic clock,
	input logic reset,
	input logic flush,
	input rename_pkg::rename_req_t [`RN_LANES-1:0] req,
	input rename_pkg::pr_idx_t [`RN_LANES-1:0] alloc_reg,
	input rename_pkg::pr_idx_t [`RN_NUM_AR-1:0] arch_image,
	output rename_pkg::rename_rsp_t [`RN_LANES-1:0] rsp
);

	rename_pkg::pr_idx_t [`RN_NUM_AR-1:0] map;

	// Lookup with bypass from older lanes in the same group.
	// Older lanes are scanned oldest first, so the youngest older writer wins
	always_comb begin
		for (int l = 0; l < `RN_LANES; l++) begin
			rsp[l].phys_src1 = map[req[l].arch_src1];
			rsp[l].phys_src2 = map[req[l].arch_src2];
			rsp[l].old_phys_dest = map[req[l].arch_dest];
			rsp[l].phys_dest = alloc_reg[l];
			for (int o = `RN_LANES - 1; o > l; o--) begin
				if (req[o].valid) begin
					if (req[o].arch_dest == req[l].arch_src1) begin
						rsp[l].phys_src1 = alloc_reg[o];
					end
					if (req[o].arch_dest == req[l].arch_src2) begin
						rsp[l].phys_src2 = alloc_reg[o];
					end
					if (req[o].arch_dest == req[l].arch_dest) begin
						rsp[l].old_phys_dest = alloc_reg[o];
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RN_NUM_AR; i++) begin
				map[i] <= rename_pkg::pr_idx_t'(i);
			end
		end else if (flush) begin
			// Requests in the flush cycle are dropped
			map <= arch_image;
		end else begin
			// Lane 0 is written last and so wins on a shared destination
			for (int l = `RN_LANES - 1; l >= 0; l--) begin
				if (req[l].valid) begin
					map[req[l].arch_dest] <= alloc_reg[l];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* retire_map.sv */
`default_nettype none

`include "rename_defines.svh"

module retire_map (
	input logic clock,
	input logic reset,
	input rename_pkg::retire_t [`RN_LANES-1:0] retire,
	output rename_pkg::pr_idx_t [`RN_LANES-1:0] freed_reg,
	output rename_pkg::pr_idx_t [`RN_NUM_AR-1:0] arch_image
);

	rename_pkg::pr_idx_t [`RN_NUM_AR-1:0] map;

	// A lane displaces the current entry unless an older retiring lane
	// wrote the same register in this cycle
	always_comb begin
		for (int l = 0; l < `RN_LANES; l++) begin
			freed_reg[l] = map[retire[l].arch_dest];
			for (int o = `RN_LANES - 1; o > l; o--) begin
				if (retire[o].valid && retire[o].arch_dest == retire[l].arch_dest) begin
					freed_reg[l] = retire[o].phys_dest;
				end
			end
		end
	end

	// The image already holds this cycle's retirements, which a same-cycle flush needs
	always_comb begin
		arch_image = map;
		for (int l = `RN_LANES - 1; l >= 0; l--) begin
			if (retire[l].valid) begin
				arch_image[retire[l].arch_dest] = retire[l].phys_dest;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RN_NUM_AR; i++) begin
				map[i] <= rename_pkg::pr_idx_t'(i);
			end
		end else begin
			map <= arch_image;
		end
	end

endmodule

`default_nettype wire

/* rename_stage.sv */
`default_nettype none

`include "rename_defines.svh"

module rename_stage (
	input logic clock,
	input logic reset,
	input logic flush,
	input rename_pkg::rename_req_t [`RN_LANES-1:0] req,
	input rename_pkg::retire_t [`RN_LANES-1:0] retire,
	output rename_pkg::rename_rsp_t [`RN_LANES-1:0] rsp,
	output logic [`RN_LANES-1:0] ready
);

	logic [`RN_LANES-1:0] pop;
	logic [`RN_LANES-1:0] push;
	rename_pkg::pr_idx_t [`RN_LANES-1:0] alloc_reg;
	rename_pkg::pr_idx_t [`RN_LANES-1:0] freed_reg;
	rename_pkg::pr_idx_t [`RN_NUM_AR-1:0] arch_image;

	for (genvar l = 0; l < `RN_LANES; l++) begin : g_lane
		assign pop[l] = req[l].valid;
		assign push[l] = retire[l].valid;
	end

	free_list u_free_list (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.pop(pop),
		.push(push),
		.push_reg(freed_reg),
		.alloc_reg(alloc_reg),
		.ready(ready)
	);

	map_table u_map_table (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.req(req),
		.alloc_reg(alloc_reg),
		.arch_image(arch_image),
		.rsp(rsp)
	);

	// Retirement is not speculative, so flush does not reach this map
	retire_map u_retire_map (
		.clock(clock),
		.reset(reset),
		.retire(retire),
		.freed_reg(freed_reg),
		.arch_image(arch_image)
	);

endmodule

`default_nettype wire

/* rename_props.sv */
`default_nettype none

`include "rename_defines.svh"

module rename_props (
	input logic clock,
	input logic reset,
	input rename_pkg::rename_req_t [`RN_LANES-1:0] req,
	input logic [`RN_LANES-1:0] ready
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [`RN_LANES-1:0] req_valid;

	always_comb begin
		for (int l = 0; l < `RN_LANES; l++) begin
			req_valid[l] = req[l].valid;
		end
	end

	valid_within_ready: assert property (@(posedge clock) disable iff (reset)
		(req_valid & ~ready) == '0)
		else $error("Request valid on a lane whose ready bit is clear");

	ready_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> ready == {`RN_LANES{1'b1}})
		else $error("Ready is not all ones in the first cycle after reset");

	// The free count only shrinks through pops and so does ready
	ready_holds_without_pop: assert property (@(posedge clock) disable iff (reset)
		req_valid == '0 |=> ready >= $past(ready))
		else $error("Ready fell in a cycle after no register was popped");

endmodule

`default_nettype wire

/* rename_tb.sv */
`default_nettype none

`include "rename_defines.svh"

module rename_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RANDOM_CYCLES = 400;
	// The directed tests need well under 100 cycles
	localparam int TEST_CYCLES = 8 + 100 + RANDOM_CYCLES;

	logic clock;
	logic reset;
	logic flush;
	rename_pkg::rename_req_t [`RN_LANES-1:0] req;
	rename_pkg::retire_t [`RN_LANES-1:0] retire;
	rename_pkg::rename_rsp_t [`RN_LANES-1:0] rsp;
	logic [`RN_LANES-1:0] ready;

	rename_pkg::pr_idx_t spec_map [`RN_NUM_AR];
	rename_pkg::pr_idx_t arch_map [`RN_NUM_AR];
	rename_pkg::pr_idx_t free_q [$];
	// Last registers pushed, oldest first; a flush makes exactly these free
	rename_pkg::pr_idx_t push_hist [$];
	rename_pkg::retire_t inflight [$];
	int errors;
	int checks;

	rename_stage u_dut (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.req(req),
		.retire(retire),
		.rsp(rsp),
		.ready(ready)
	);

	bind rename_stage rename_props u_props (
		.clock(clock),
		.reset(reset),
		.req(req),
		.ready(ready)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic check_value(input string what, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic model_reset();
		free_q.delete();
		push_hist.delete();
		inflight.delete();
		for (int i = 0; i < `RN_NUM_AR; i++) begin
			spec_map[i] = rename_pkg::pr_idx_t'(i);
			arch_map[i] = rename_pkg::pr_idx_t'(i);
		end
		for (int i = `RN_NUM_AR; i < `RN_NUM_PR; i++) begin
			free_q.push_back(rename_pkg::pr_idx_t'(i));
			push_hist.push_back(rename_pkg::pr_idx_t'(i));
		end
	endtask

	function automatic logic [`RN_LANES-1:0] expected_ready();
		int n;
		n = free_q.size();
		if (n >= 3) return 3'b111;
		else if (n == 2) return 3'b110;
		else if (n == 1) return 3'b100;
		else return 3'b000;
	endfunction

	function automatic int cap_lanes(input int want, input int avail);
		return (want < avail) ? want : avail;
	endfunction

	function automatic rename_pkg::rename_req_t make_req(input int dest, input int src1,
			input int src2);
		rename_pkg::rename_req_t r;
		r.valid = 1'b1;
		r.arch_dest = rename_pkg::ar_idx_t'(dest);
		r.arch_src1 = rename_pkg::ar_idx_t'(src1);
		r.arch_src2 = rename_pkg::ar_idx_t'(src2);
		return r;
	endfunction

	// Fills the n oldest lanes with random instructions
	task automatic make_group(input int n, output rename_pkg::rename_req_t [`RN_LANES-1:0] rq);
		rq = '0;
		for (int l = `RN_LANES - 1; l >= `RN_LANES - n; l--) begin
			rq[l] = make_req(int'($urandom % 32), int'($urandom % 32), int'($urandom % 32));
		end
	endtask

	task automatic take_retires(input int n, output rename_pkg::retire_t [`RN_LANES-1:0] rt);
		rt = '0;
		for (int l = `RN_LANES - 1; l >= `RN_LANES - n; l--) begin
			rt[l] = inflight.pop_front();
		end
	endtask

	task automatic run_cycle(input rename_pkg::rename_req_t [`RN_LANES-1:0] rq,
			input rename_pkg::retire_t [`RN_LANES-1:0] rt, input logic fl);
		rename_pkg::pr_idx_t exp_dest;
		rename_pkg::retire_t entry;
		@(posedge clock);
		#2;
		req = rq;
		retire = rt;
		flush = fl;
		#16;
		check_value("ready", int'(ready), int'(expected_ready()));
		for (int l = `RN_LANES - 1; l >= 0; l--) begin
			if (!fl && rq[l].valid) begin
				exp_dest = free_q.pop_front();
				check_value($sformatf("lane %0d phys_src1", l), int'(rsp[l].phys_src1),
					int'(spec_map[rq[l].arch_src1]));
				check_value($sformatf("lane %0d phys_src2", l), int'(rsp[l].phys_src2),
					int'(spec_map[rq[l].arch_src2]));
				check_value($sformatf("lane %0d old_phys_dest", l), int'(rsp[l].old_phys_dest),
					int'(spec_map[rq[l].arch_dest]));
				check_value($sformatf("lane %0d phys_dest", l), int'(rsp[l].phys_dest),
					int'(exp_dest));
				spec_map[rq[l].arch_dest] = exp_dest;
				entry.valid = 1'b1;
				entry.arch_dest = rq[l].arch_dest;
				entry.phys_dest = exp_dest;
				inflight.push_back(entry);
			end
		end
		for (int l = `RN_LANES - 1; l >= 0; l--) begin
			if (rt[l].valid) begin
				free_q.push_back(arch_map[rt[l].arch_dest]);
				push_hist.push_back(arch_map[rt[l].arch_dest]);
				arch_map[rt[l].arch_dest] = rt[l].phys_dest;
			end
		end
		while (push_hist.size() > `RN_FL_DEPTH) begin
			push_hist.delete(0);
		end
		if (fl) begin
			spec_map = arch_map;
			free_q = push_hist;
			inflight.delete();
		end
	endtask

	task automatic test_reset_mapping();
		rename_pkg::rename_req_t [`RN_LANES-1:0] rq;
		for (int i = 0; i < 3; i++) begin
			rq = '0;
			rq[2] = make_req(5 + i, 10 + i, 20 + i);
			run_cycle(rq, '0, 1'b0);
			check_value("phys_src1 after reset", int'(rsp[2].phys_src1), 10 + i);
			check_value("old_phys_dest after reset", int'(rsp[2].old_phys_dest), 5 + i);
			check_value("phys_dest after reset", int'(rsp[2].phys_dest), `RN_NUM_AR + i);
		end
	endtask

	task automatic test_group_dependence();
		rename_pkg::rename_req_t [`RN_LANES-1:0] rq;
		rename_pkg::pr_idx_t first;
		rename_pkg::pr_idx_t second;
		rename_pkg::pr_idx_t third;
		first = free_q[0];
		second = free_q[1];
		third = free_q[2];
		rq[2] = make_req(7, 1, 2);
		rq[1] = make_req(8, 7, 3);
		rq[0] = make_req(7, 8, 7);
		run_cycle(rq, '0, 1'b0);
		check_value("lane 1 source from lane 2", int'(rsp[1].phys_src1), int'(first));
		check_value("lane 0 old dest from lane 2", int'(rsp[0].old_phys_dest), int'(first));
		check_value("lane 0 source from lane 1", int'(rsp[0].phys_src1), int'(second));
		rq = '0;
		rq[2] = make_req(9, 7, 8);
		run_cycle(rq, '0, 1'b0);
		check_value("next group sees lane 0", int'(rsp[2].phys_src1), int'(third));
		check_value("next group sees lane 1", int'(rsp[2].phys_src2), int'(second));
	endtask

	task automatic test_exhaustion();
		rename_pkg::rename_req_t [`RN_LANES-1:0] rq;
		rename_pkg::retire_t [`RN_LANES-1:0] rt;
		rename_pkg::pr_idx_t displaced;
		// One lane per cycle so ready steps through every pattern
		for (int i = 0; i < 40 && free_q.size() > 0; i++) begin
			make_group(1, rq);
			run_cycle(rq, '0, 1'b0);
		end
		run_cycle('0, '0, 1'b0);
		check_value("ready with no free register", int'(ready), 0);
		displaced = arch_map[inflight[0].arch_dest];
		take_retires(1, rt);
		run_cycle('0, rt, 1'b0);
		make_group(1, rq);
		run_cycle(rq, '0, 1'b0);
		check_value("ready after one retirement", int'(ready), 4);
		check_value("reallocated register", int'(rsp[2].phys_dest), int'(displaced));
	endtask

	task automatic test_flush_recovery();
		rename_pkg::rename_req_t [`RN_LANES-1:0] rq;
		rename_pkg::retire_t [`RN_LANES-1:0] rt;
		rename_pkg::ar_idx_t last_dest;
		for (int c = 0; c < 3; c++) begin
			make_group(cap_lanes(3, free_q.size()), rq);
			take_retires(cap_lanes(3, inflight.size()), rt);
			run_cycle(rq, rt, 1'b0);
		end
		take_retires(cap_lanes(2, inflight.size()), rt);
		last_dest = rt[2].arch_dest;
		// The group sent with the flush must leave no trace
		make_group(cap_lanes(3, free_q.size()), rq);
		run_cycle(rq, rt, 1'b1);
		make_group(3, rq);
		rq[2].arch_src1 = last_dest;
		run_cycle(rq, '0, 1'b0);
		check_value("ready after flush", int'(ready), 7);
		check_value("source retired in flush cycle", int'(rsp[2].phys_src1),
			int'(arch_map[last_dest]));
		while (free_q.size() > 0) begin
			make_group(cap_lanes(3, free_q.size()), rq);
			run_cycle(rq, '0, 1'b0);
		end
		run_cycle('0, '0, 1'b0);
	endtask

	task automatic test_random_traffic();
		rename_pkg::rename_req_t [`RN_LANES-1:0] rq;
		rename_pkg::retire_t [`RN_LANES-1:0] rt;
		int n_req;
		int n_ret;
		logic fl;
		for (int c = 0; c < RANDOM_CYCLES; c++) begin
			fl = ($urandom % 32) == 0;
			n_ret = cap_lanes(int'($urandom % 4), inflight.size());
			n_req = cap_lanes(int'($urandom % 4), free_q.size());
			make_group(n_req, rq);
			take_retires(n_ret, rt);
			run_cycle(rq, rt, fl);
		end
	endtask

	initial begin
		#(TEST_CYCLES * 40 + 2000);
		$display("Watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(32'hb70ca18a));
		errors = 0;
		checks = 0;
		reset = 1'b1;
		flush = 1'b0;
		req = '0;
		retire = '0;
		model_reset();
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		test_reset_mapping();
		test_group_dependence();
		test_exhaustion();
		test_flush_recovery();
		test_random_traffic();
		$display("Rename testbench done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rename.f */
+incdir+.
rename_pkg.sv
free_list.sv
map_table.sv
retire_map.sv
rename_stage.sv
rename_props.sv
rename_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the rename stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rename.f --top-module rename_tb -o rename_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qxF '*** TEST PASSED ***' "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1
